//--- verilog/axi_pkg.sv
package axi_pkg;

	// bus widths shared by every block on the memory path
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;

	// response codes, axi encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_DECERR = 2'b11
	} resp_e;

	// requester tag carried with a read address
	// only lsu writes, so the write side has no tag
	typedef enum logic {
		ID_IFU = 1'b0,
		ID_LSU = 1'b1
	} req_id_e;

endpackage

//--- verilog/mem_pkg.sv
package mem_pkg;

	// memory window, byte addressed
	localparam logic [axi_pkg::ADDR_W-1:0] MEM_BASE = 32'h8000_0000;

	// 256 words of 64 bits, 2 KiB
	localparam int MEM_WORDS = 256;
	localparam int IDX_W = 8;

	// read side of the sram slave
	typedef enum logic [1:0] {
		RD_IDLE = 2'b00,
		RD_RESP = 2'b01
	} rd_state_e;

	// write side of the sram slave
	typedef enum logic [1:0] {
		WR_IDLE = 2'b00,
		WR_RESP = 2'b01
	} wr_state_e;

endpackage

//--- verilog/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;

	// read address
	logic                          arvalid;
	logic                          arready;
	logic [axi_pkg::ADDR_W-1:0]    araddr;
	axi_pkg::req_id_e              arid;

	// read data
	logic                          rvalid;
	logic                          rready;
	logic [axi_pkg::DATA_W-1:0]    rdata;
	axi_pkg::resp_e                rresp;
	axi_pkg::req_id_e              rid;

	// write address and data, accepted together
	logic                          awvalid;
	logic                          awready;
	logic [axi_pkg::ADDR_W-1:0]    awaddr;
	logic                          wvalid;
	logic                          wready;
	logic [axi_pkg::DATA_W-1:0]    wdata;
	logic [axi_pkg::STRB_W-1:0]    wstrb;

	// write response
	logic                          bvalid;
	logic                          bready;
	axi_pkg::resp_e                bresp;

	// arbiter side, watches both response handshakes to drop its lock
	modport arb (
		output arvalid, araddr, arid, awvalid, awaddr, wvalid, wdata, wstrb,
		input  arready, awready, wready, rvalid, rready, bvalid, bready
	);

	modport slave (
		input  arvalid, araddr, arid, awvalid, awaddr, wvalid, wdata, wstrb,
		input  rready, bready,
		output arready, awready, wready, rvalid, rdata, rresp, rid, bvalid, bresp
	);

	// response steering back to the requesters
	modport router (
		input  rvalid, rdata, rresp, rid, bvalid, bresp,
		output rready, bready
	);

endinterface

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ifu_arvalid,
	input  logic [axi_pkg::ADDR_W-1:0] ifu_araddr,
	input  logic                       lsu_arvalid,
	input  logic [axi_pkg::ADDR_W-1:0] lsu_araddr,
	input  logic                       lsu_awvalid,
	input  logic [axi_pkg::ADDR_W-1:0] lsu_awaddr,
	input  logic                       lsu_wvalid,
	input  logic [axi_pkg::DATA_W-1:0] lsu_wdata,
	input  logic [axi_pkg::STRB_W-1:0] lsu_wstrb,
	output logic                       ifu_arready,
	output logic                       lsu_arready,
	output logic                       lsu_awready,
	output logic                       lsu_wready,
	mem_bus_if.arb                     bus
);

	logic             lock;
	axi_pkg::req_id_e last_win;
	axi_pkg::req_id_e win_id;
	logic             lsu_wr_req;
	logic             lsu_req;
	logic             gnt_ifu;
	logic             gnt_lsu;
	logic             lsu_do_wr;
	logic             addr_hs;
	logic             resp_hs;

	// a write counts only once address and data are both offered
	assign lsu_wr_req = lsu_awvalid & lsu_wvalid;
	assign lsu_req    = lsu_arvalid | lsu_wr_req;

	// round robin on a tie, lsu wins unless it won last time
	assign gnt_lsu = ~lock & lsu_req & (~ifu_arvalid | (last_win == axi_pkg::ID_IFU));
	assign gnt_ifu = ~lock & ifu_arvalid & ~gnt_lsu;
	assign win_id  = gnt_ifu ? axi_pkg::ID_IFU : axi_pkg::ID_LSU;

	// lsu read goes ahead of a pending lsu write
	assign lsu_do_wr = gnt_lsu & ~lsu_arvalid;

	// winner onto the bus
	assign bus.arvalid = gnt_ifu | (gnt_lsu & lsu_arvalid);
	assign bus.araddr  = gnt_ifu ? ifu_araddr : lsu_araddr;
	assign bus.arid    = win_id;
	assign bus.awvalid = lsu_do_wr & lsu_awvalid;
	assign bus.wvalid  = lsu_do_wr & lsu_wvalid;
	assign bus.awaddr  = lsu_awaddr;
	assign bus.wdata   = lsu_wdata;
	assign bus.wstrb   = lsu_wstrb;

	// slave ready goes back to the winner only
	assign ifu_arready = gnt_ifu & bus.arready;
	assign lsu_arready = gnt_lsu & lsu_arvalid & bus.arready;
	assign lsu_awready = lsu_do_wr & bus.awready;
	assign lsu_wready  = lsu_do_wr & bus.wready;

	assign addr_hs = (bus.arvalid & bus.arready) |
	                 (bus.awvalid & bus.awready & bus.wvalid & bus.wready);
	assign resp_hs = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);

	// lock from address handshake until the matching response is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			lock     <= 1'b0;
			last_win <= axi_pkg::ID_IFU;
		end else if (addr_hs) begin
			lock     <= 1'b1;
			last_win <= win_id;
		end else if (resp_hs) begin
			lock     <= 1'b0;
		end
	end

	// nothing accepted while a response is still pending
	a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
		(bus.rvalid || bus.bvalid) |-> !(ifu_arready || lsu_arready || lsu_awready));

endmodule

//--- verilog/sram_slave.sv
`timescale 1ns/1ns

module sram_slave (
	input  logic     clk,
	input  logic     rst,
	mem_bus_if.slave bus
);

	mem_pkg::rd_state_e            rd_state;
	mem_pkg::wr_state_e            wr_state;
	logic [axi_pkg::DATA_W-1:0]    mem [0:mem_pkg::MEM_WORDS-1];
	logic [axi_pkg::ADDR_W-1:0]    rd_off;
	logic [axi_pkg::ADDR_W-1:0]    wr_off;
	logic                          rd_hit;
	logic                          wr_hit;
	logic [mem_pkg::IDX_W-1:0]     rd_idx;
	logic [mem_pkg::IDX_W-1:0]     wr_idx;
	logic                          rd_hs;
	logic                          wr_hs;

	// offset from window base, wraps below base so one compare covers both ends
	assign rd_off = bus.araddr - mem_pkg::MEM_BASE;
	assign wr_off = bus.awaddr - mem_pkg::MEM_BASE;
	assign rd_hit = (rd_off[axi_pkg::ADDR_W-1:mem_pkg::IDX_W+3] == '0);
	assign wr_hit = (wr_off[axi_pkg::ADDR_W-1:mem_pkg::IDX_W+3] == '0);
	// word index, byte offset bits dropped
	assign rd_idx = rd_off[mem_pkg::IDX_W+2:3];
	assign wr_idx = wr_off[mem_pkg::IDX_W+2:3];

	// ready only while idle
	assign bus.arready = (rd_state == mem_pkg::RD_IDLE);
	assign bus.awready = (wr_state == mem_pkg::WR_IDLE) & bus.awvalid & bus.wvalid;
	assign bus.wready  = (wr_state == mem_pkg::WR_IDLE) & bus.awvalid & bus.wvalid;
	assign bus.rvalid  = (rd_state == mem_pkg::RD_RESP);
	assign bus.bvalid  = (wr_state == mem_pkg::WR_RESP);

	assign rd_hs = bus.arvalid & bus.arready;
	assign wr_hs = bus.awvalid & bus.awready & bus.wvalid & bus.wready;

	// read fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= mem_pkg::RD_IDLE;
		end else if (rd_hs) begin
			rd_state <= mem_pkg::RD_RESP;
		end else if (bus.rvalid && bus.rready) begin
			rd_state <= mem_pkg::RD_IDLE;
		end
	end

	// read payload, held until the next address handshake
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			bus.rdata <= rd_hit ? mem[rd_idx] : '0;
			bus.rresp <= rd_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
			bus.rid   <= bus.arid;
		end
	end

	// write fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= mem_pkg::WR_IDLE;
		end else if (wr_hs) begin
			wr_state <= mem_pkg::WR_RESP;
		end else if (bus.bvalid && bus.bready) begin
			wr_state <= mem_pkg::WR_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bus.bresp <= wr_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
		end
	end

	// byte merge under strobe, miss leaves memory alone
	always_ff @(posedge clk) begin
		if (wr_hs && wr_hit) begin
			for (int b = 0; b < axi_pkg::STRB_W; b++) begin
				if (bus.wstrb[b])
					mem[wr_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
	end

	// read response and its payload hold under back-pressure
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=>
		bus.rvalid && $stable(bus.rdata) && $stable(bus.rresp));

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

endmodule

//--- verilog/resp_router.sv
`timescale 1ns/1ns

module resp_router (
	input  logic                       clk,
	input  logic                       rst,
	output logic                       ifu_rvalid,
	output logic [axi_pkg::DATA_W-1:0] ifu_rdata,
	output axi_pkg::resp_e             ifu_rresp,
	output logic                       lsu_rvalid,
	output logic [axi_pkg::DATA_W-1:0] lsu_rdata,
	output axi_pkg::resp_e             lsu_rresp,
	output logic                       lsu_bvalid,
	output axi_pkg::resp_e             lsu_bresp,
	input  logic                       ifu_rready,
	input  logic                       lsu_rready,
	input  logic                       lsu_bready,
	mem_bus_if.router                  bus
);

	logic to_ifu;

	// read channel steered by the echoed id
	assign to_ifu     = (bus.rid == axi_pkg::ID_IFU);
	assign ifu_rvalid = bus.rvalid & to_ifu;
	assign lsu_rvalid = bus.rvalid & ~to_ifu;
	// payload fans out, valid picks the owner
	assign ifu_rdata  = bus.rdata;
	assign lsu_rdata  = bus.rdata;
	assign ifu_rresp  = bus.rresp;
	assign lsu_rresp  = bus.rresp;
	assign bus.rready = to_ifu ? ifu_rready : lsu_rready;

	// writes only come from lsu
	assign lsu_bvalid = bus.bvalid;
	assign lsu_bresp  = bus.bresp;
	assign bus.bready = lsu_bready;

	// owner of a pending response never switches mid-stall
	a_rid_stable: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=> $stable(bus.rid));

endmodule

//--- verilog/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys (
	input  logic                       clk,
	input  logic                       rst,
	// instruction fetch, read only
	input  logic                       ifu_arvalid,
	input  logic [axi_pkg::ADDR_W-1:0] ifu_araddr,
	output logic                       ifu_arready,
	output logic                       ifu_rvalid,
	output logic [axi_pkg::DATA_W-1:0] ifu_rdata,
	output axi_pkg::resp_e             ifu_rresp,
	input  logic                       ifu_rready,
	// load/store
	input  logic                       lsu_arvalid,
	input  logic [axi_pkg::ADDR_W-1:0] lsu_araddr,
	output logic                       lsu_arready,
	output logic                       lsu_rvalid,
	output logic [axi_pkg::DATA_W-1:0] lsu_rdata,
	output axi_pkg::resp_e             lsu_rresp,
	input  logic                       lsu_rready,
	input  logic                       lsu_awvalid,
	input  logic [axi_pkg::ADDR_W-1:0] lsu_awaddr,
	output logic                       lsu_awready,
	input  logic                       lsu_wvalid,
	input  logic [axi_pkg::DATA_W-1:0] lsu_wdata,
	input  logic [axi_pkg::STRB_W-1:0] lsu_wstrb,
	output logic                       lsu_wready,
	output logic                       lsu_bvalid,
	output axi_pkg::resp_e             lsu_bresp,
	input  logic                       lsu_bready
);

	mem_bus_if bus ();

	// request side
	mem_arbiter u_arb (
		.clk         (clk),
		.rst         (rst),
		.ifu_arvalid (ifu_arvalid),
		.ifu_araddr  (ifu_araddr),
		.lsu_arvalid (lsu_arvalid),
		.lsu_araddr  (lsu_araddr),
		.lsu_awvalid (lsu_awvalid),
		.lsu_awaddr  (lsu_awaddr),
		.lsu_wvalid  (lsu_wvalid),
		.lsu_wdata   (lsu_wdata),
		.lsu_wstrb   (lsu_wstrb),
		.ifu_arready (ifu_arready),
		.lsu_arready (lsu_arready),
		.lsu_awready (lsu_awready),
		.lsu_wready  (lsu_wready),
		.bus         (bus.arb)
	);

	sram_slave u_sram (
		.clk (clk),
		.rst (rst),
		.bus (bus.slave)
	);

	// response side
	resp_router u_router (
		.clk        (clk),
		.rst        (rst),
		.ifu_rvalid (ifu_rvalid),
		.ifu_rdata  (ifu_rdata),
		.ifu_rresp  (ifu_rresp),
		.lsu_rvalid (lsu_rvalid),
		.lsu_rdata  (lsu_rdata),
		.lsu_rresp  (lsu_rresp),
		.lsu_bvalid (lsu_bvalid),
		.lsu_bresp  (lsu_bresp),
		.ifu_rready (ifu_rready),
		.lsu_rready (lsu_rready),
		.lsu_bready (lsu_bready),
		.bus        (bus.router)
	);

endmodule

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;

	localparam int TIMEOUT = 100;
	localparam logic [31:0] BASE = mem_pkg::MEM_BASE;
	// event codes for wait_for
	localparam int EV_AR = 0;
	localparam int EV_RV = 1;
	localparam int EV_R  = 2;
	localparam int EV_W  = 3;
	localparam int EV_BV = 4;
	localparam int EV_B  = 5;

	logic           clk;
	logic           rst;
	logic           ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic           lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic           lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
	logic           lsu_bvalid, lsu_bready;
	logic [31:0]    ifu_araddr, lsu_araddr, lsu_awaddr;
	logic [63:0]    ifu_rdata, lsu_rdata, lsu_wdata;
	logic [7:0]     lsu_wstrb;
	axi_pkg::resp_e ifu_rresp, lsu_rresp, lsu_bresp;

	// shadow copy of the sram plus expected responses in issue order
	logic [63:0]    shadow [0:mem_pkg::MEM_WORDS-1];
	logic [65:0]    exp_ifu[$];
	logic [65:0]    exp_lsu[$];
	axi_pkg::resp_e exp_b[$];
	string          test_name;
	int             errors;
	int             err_base;
	int             checks;
	int             tests;

	mem_subsys uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// 2 KiB window starting at the base
	function automatic logic in_window(input logic [31:0] addr);
		return addr >= BASE && addr < BASE + 32'(mem_pkg::MEM_WORDS * 8);
	endfunction

	// expected {resp, data} of a read
	function automatic logic [65:0] ref_read(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - BASE;
		if (!in_window(addr))
			return {axi_pkg::RESP_DECERR, 64'h0};
		return {axi_pkg::RESP_OKAY, shadow[off[10:3]]};
	endfunction

	// byte merge into the shadow, outside the window nothing moves
	function automatic axi_pkg::resp_e ref_write(input logic [31:0] addr,
			input logic [63:0] data, input logic [7:0] strb);
		logic [31:0] off;
		off = addr - BASE;
		if (!in_window(addr))
			return axi_pkg::RESP_DECERR;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				shadow[off[10:3]][b*8 +: 8] = data[b*8 +: 8];
		end
		return axi_pkg::RESP_OKAY;
	endfunction

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error: %s, %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// values as seen just before the edge
	function automatic logic seen(input int ev, input logic is_ifu);
		case (ev)
			EV_AR: return is_ifu ? ifu_arvalid && ifu_arready : lsu_arvalid && lsu_arready;
			EV_RV: return is_ifu ? ifu_rvalid : lsu_rvalid;
			EV_R: return is_ifu ? ifu_rvalid && ifu_rready : lsu_rvalid && lsu_rready;
			EV_W: return lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready;
			EV_BV: return lsu_bvalid;
			default: return lsu_bvalid && lsu_bready;
		endcase
	endfunction

	task automatic wait_for(input int ev, input logic is_ifu, input string what);
		int n;
		n = 0;
		forever begin
			@(posedge clk);
			if (seen(ev, is_ifu))
				break;
			n++;
			if (n == TIMEOUT) begin
				errors++;
				$display("%s: no %s within %0d cycles", test_name, what, TIMEOUT);
				break;
			end
		end
	endtask

	// rready stays low for stall cycles once rvalid is up
	task automatic do_read(input axi_pkg::req_id_e who, input logic [31:0] addr,
			input int stall);
		logic [63:0] held;
		logic        is_ifu;
		is_ifu = (who == axi_pkg::ID_IFU);
		@(negedge clk);
		if (is_ifu) begin
			exp_ifu.push_back(ref_read(addr));
			ifu_araddr  = addr;
			ifu_arvalid = 1'b1;
		end else begin
			exp_lsu.push_back(ref_read(addr));
			lsu_araddr  = addr;
			lsu_arvalid = 1'b1;
		end
		wait_for(EV_AR, is_ifu, "read address handshake");
		@(negedge clk);
		if (is_ifu)
			ifu_arvalid = 1'b0;
		else
			lsu_arvalid = 1'b0;
		wait_for(EV_RV, is_ifu, "rvalid");
		held = is_ifu ? ifu_rdata : lsu_rdata;
		repeat (stall) begin
			@(posedge clk);
			check("rvalid held", 64'd1, 64'(is_ifu ? ifu_rvalid : lsu_rvalid));
			check("rdata held", held, is_ifu ? ifu_rdata : lsu_rdata);
		end
		@(negedge clk);
		if (is_ifu)
			ifu_rready = 1'b1;
		else
			lsu_rready = 1'b1;
		wait_for(EV_R, is_ifu, "read data handshake");
		@(negedge clk);
		if (is_ifu)
			ifu_rready = 1'b0;
		else
			lsu_rready = 1'b0;
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input int stall);
		exp_b.push_back(ref_write(addr, data, strb));
		@(negedge clk);
		lsu_awaddr  = addr;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		wait_for(EV_W, 1'b0, "write handshake");
		@(negedge clk);
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		wait_for(EV_BV, 1'b0, "bvalid");
		// lock held, ifu has to wait
		repeat (stall) begin
			@(posedge clk);
			check("bvalid held", 64'd1, 64'(lsu_bvalid));
			check("ifu_arready while locked", 64'd0, 64'(ifu_arready));
		end
		@(negedge clk);
		lsu_bready = 1'b1;
		wait_for(EV_B, 1'b0, "write response handshake");
		@(negedge clk);
		lsu_bready = 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_base  = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %s, %0d errors", test_name,
			errors == err_base ? "ok" : "bad", errors - err_base);
	endtask

	// compare process, one pop per response handshake
	initial begin
		logic [65:0] e;
		forever begin
			@(posedge clk);
			if (!rst) begin
				// a response nobody asked for means misrouting
				if (ifu_rvalid && exp_ifu.size() == 0) begin
					errors++;
					$display("%s: ifu rvalid raised with no ifu read pending", test_name);
				end
				if (lsu_rvalid && exp_lsu.size() == 0) begin
					errors++;
					$display("%s: lsu rvalid raised with no lsu read pending", test_name);
				end
				if (ifu_rvalid && ifu_rready && exp_ifu.size() != 0) begin
					e = exp_ifu.pop_front();
					check("ifu rdata", e[63:0], ifu_rdata);
					check("ifu rresp", 64'(e[65:64]), 64'(ifu_rresp));
				end
				if (lsu_rvalid && lsu_rready && exp_lsu.size() != 0) begin
					e = exp_lsu.pop_front();
					check("lsu rdata", e[63:0], lsu_rdata);
					check("lsu rresp", 64'(e[65:64]), 64'(lsu_rresp));
				end
				if (lsu_bvalid && lsu_bready && exp_b.size() != 0)
					check("lsu bresp", 64'(exp_b.pop_front()), 64'(lsu_bresp));
			end
		end
	end

	initial begin
		logic [31:0] addr [0:7];
		logic [31:0] a;
		void'($urandom(5));
		rst = 1'b1;
		{ifu_arvalid, ifu_rready, lsu_arvalid, lsu_rready} = '0;
		{lsu_awvalid, lsu_wvalid, lsu_bready} = '0;
		ifu_araddr = '0;
		lsu_araddr = '0;
		lsu_awaddr = '0;
		lsu_wdata  = '0;
		lsu_wstrb  = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		begin_test("reset and full-word writes");
		check("outputs after reset", 64'd0, 64'({ifu_rvalid, lsu_rvalid, lsu_bvalid,
			ifu_arready, lsu_arready, lsu_awready, lsu_wready}));
		// fill every word, pattern from the full address
		for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
			a = BASE + 32'(i * 8);
			do_write(a, {~a, a}, 8'hFF, 0);
		end
		for (int i = 0; i < 8; i++) begin
			addr[i] = BASE + {21'h0, 8'($urandom_range(0, 255)), 3'h0};
			do_write(addr[i], {$urandom, $urandom}, 8'hFF, 0);
		end
		for (int i = 0; i < 8; i++)
			do_read(axi_pkg::ID_LSU, addr[i], 0);
		end_test();

		begin_test("byte strobes");
		for (int i = 0; i < 8; i++) begin
			do_write(addr[i], {$urandom, $urandom}, 8'($urandom_range(1, 254)), 0);
			do_read(axi_pkg::ID_LSU, addr[i], 0);
		end
		end_test();

		begin_test("fetch sees stored data");
		for (int i = 0; i < 8; i++)
			do_read(axi_pkg::ID_IFU, addr[i], 0);
		end_test();

		begin_test("out-of-range access");
		// below and above the window, these alias words 255 and 0 if decode wraps
		do_write(32'h7FFF_FFF8, {$urandom, $urandom}, 8'hFF, 0);
		do_write(32'h8000_0800, {$urandom, $urandom}, 8'hFF, 0);
		do_read(axi_pkg::ID_LSU, 32'h8000_0800, 0);
		do_read(axi_pkg::ID_IFU, 32'h7FFF_FFF8, 0);
		do_read(axi_pkg::ID_LSU, BASE + 32'h7F8, 0);
		do_read(axi_pkg::ID_LSU, BASE, 0);
		end_test();

		begin_test("contention");
		for (int i = 0; i < 4; i++) begin
			fork
				do_read(axi_pkg::ID_IFU, BASE + 32'(i * 16), 0);
				do_read(axi_pkg::ID_LSU, BASE + 32'(i * 16 + 8), 0);
			join
		end
		end_test();

		begin_test("back-pressure");
		for (int i = 0; i < 4; i++)
			do_read(axi_pkg::req_id_e'(i[0]), addr[i], int'($urandom_range(1, 8)));
		// fetch arrives while bready is held low
		fork
			do_write(addr[0], {$urandom, $urandom}, 8'hFF, int'($urandom_range(2, 8)));
			begin
				wait_for(EV_BV, 1'b0, "bvalid");
				do_read(axi_pkg::ID_IFU, addr[0], 0);
			end
		join
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- project.f
verilog/axi_pkg.sv
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_arbiter.sv
verilog/sram_slave.sv
verilog/resp_router.sv
verilog/mem_subsys.sv
tests/tb_mem_subsys.sv

//--- Makefile
TOP = tb_mem_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
